// File: logic/trace_matcher.sv
// byte window with masked pattern compare and saturating match counters
`timescale 1ns/1ps
`default_nettype none

module trace_matcher #(
  parameter int BUFFER_BYTES = 4,
  parameter int MATCH_RULES  = 4
) (
  input  wire                                   trigger_clk,
  input  wire                                   reset,
  input  wire trace_pkg::trace_byte_t           trace_byte,
  input  wire                                   trace_valid,
  input  wire [MATCH_RULES*BUFFER_BYTES*8-1:0]  rule_patterns,
  input  wire [MATCH_RULES*BUFFER_BYTES*8-1:0]  rule_masks,
  input  wire [MATCH_RULES-1:0]                 pattern_enable,
  output logic [MATCH_RULES-1:0]                rule_match,
  output logic [MATCH_RULES*8-1:0]              match_counts
);

  localparam int BUF_W = BUFFER_BYTES * 8;
  localparam int CNT_W = $bits(trace_pkg::match_count_t);

  logic [BUF_W-1:0]       window;
  logic                   window_new;  // window shifted on the last edge
  logic [MATCH_RULES-1:0] rule_hit;

  // newest byte enters at the bottom, oldest drops off the top
  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      window     <= '0;
      window_new <= 1'b0;
    end else begin
      window_new <= trace_valid;
      if (trace_valid)
        window <= BUF_W'({window, trace_byte});
    end
  end

  // all rules compared in parallel every cycle
  always_comb begin
    for (int r = 0; r < MATCH_RULES; r++) begin
      rule_hit[r] = pattern_enable[r]
                  & ~|((window ^ rule_patterns[r*BUF_W +: BUF_W])
                       & rule_masks[r*BUF_W +: BUF_W]);
    end
  end

  // flags and counts only on a freshly shifted window
  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      rule_match   <= '0;
      match_counts <= '0;
    end else begin
      rule_match <= window_new ? rule_hit : '0;
      for (int r = 0; r < MATCH_RULES; r++) begin
        if (window_new && rule_hit[r] && (match_counts[r*CNT_W +: CNT_W] != '1))
          match_counts[r*CNT_W +: CNT_W] <= match_counts[r*CNT_W +: CNT_W]
                                          + trace_pkg::match_count_t'(1);
      end
    end
  end

  // a full counter stays full
  for (genvar r = 0; r < MATCH_RULES; r++) begin : g_cnt_check
    a_count_no_wrap : assert property (
      @(posedge trigger_clk) disable iff (reset)
      (match_counts[r*CNT_W +: CNT_W] == '1) |=> (match_counts[r*CNT_W +: CNT_W] != '0)
    );
  end

endmodule

`default_nettype wire

// File: logic/trace_pkg.sv
// trace trigger shared types and APB register map
`default_nettype none

package trace_pkg;

  // bus side
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // trace side
  typedef logic [7:0]  trace_byte_t;
  typedef logic [7:0]  match_count_t;  // saturates at 255
  typedef logic [3:0]  trig_num_t;

  // register offsets, byte addresses
  localparam apb_addr_t ADDR_CTRL         = 8'h00;
  localparam apb_addr_t ADDR_RULE_EN      = 8'h04;
  localparam apb_addr_t ADDR_STATUS       = 8'h08;  // read only
  localparam apb_addr_t ADDR_ARM          = 8'h0C;
  localparam apb_addr_t ADDR_PATTERN_BASE = 8'h10;
  localparam apb_addr_t ADDR_COUNT_BASE   = 8'h40;  // read only

  // per rule address layout
  localparam int RULE_STRIDE  = 8;  // pattern then mask
  localparam int MASK_OFFSET  = 4;
  localparam int COUNT_STRIDE = 4;

  // field positions
  localparam int CTRL_NUM_LSB    = 4;   // num_triggers in ctrl[7:4]
  localparam int RULE_EN_TRG_LSB = 8;   // trig enables start here
  localparam int STATUS_ARMED    = 8;

endpackage

`default_nettype wire

// File: logic/trace_regs.sv
// APB register file for match rules, trigger setup and status readback
`timescale 1ns/1ps
`default_nettype none

module trace_regs #(
  parameter int BUFFER_BYTES = 4,
  parameter int MATCH_RULES  = 4
) (
  input  wire                                trigger_clk,
  input  wire                                reset,
  // APB slave
  input  wire                                psel,
  input  wire                                penable,
  input  wire                                pwrite,
  input  wire trace_pkg::apb_addr_t          paddr,
  input  wire trace_pkg::apb_data_t          pwdata,
  output trace_pkg::apb_data_t               prdata,
  output logic                               pready,
  output logic                               pslverr,
  // status in
  input  wire [MATCH_RULES*8-1:0]            match_counts,
  input  wire                                armed,
  input  wire trace_pkg::trig_num_t          triggers_generated,
  // configuration out
  output logic [MATCH_RULES*BUFFER_BYTES*8-1:0] rule_patterns,
  output logic [MATCH_RULES*BUFFER_BYTES*8-1:0] rule_masks,
  output logic [MATCH_RULES-1:0]             pattern_enable,
  output logic [MATCH_RULES-1:0]             trig_enable,
  output logic                               trigger_enable,
  output trace_pkg::trig_num_t               num_triggers,
  output logic                               arm_pulse
);

  localparam int BUF_W = BUFFER_BYTES * 8;
  localparam int CNT_W = $bits(trace_pkg::match_count_t);
  localparam int NUM_W = $bits(trace_pkg::trig_num_t);

  logic                   access;
  logic                   wr_en;
  logic                   hit_ctrl;
  logic                   hit_rule_en;
  logic                   hit_status;
  logic                   hit_arm;
  logic [MATCH_RULES-1:0] hit_pat;
  logic [MATCH_RULES-1:0] hit_mask;
  logic [MATCH_RULES-1:0] hit_cnt;
  logic                   mapped;
  logic                   read_only;

  assign access = psel & penable;   // access phase
  assign wr_en  = access & pwrite;
  assign pready = 1'b1;             // zero wait states

  // address decode
  assign hit_ctrl    = (paddr == trace_pkg::ADDR_CTRL);
  assign hit_rule_en = (paddr == trace_pkg::ADDR_RULE_EN);
  assign hit_status  = (paddr == trace_pkg::ADDR_STATUS);
  assign hit_arm     = (paddr == trace_pkg::ADDR_ARM);

  always_comb begin
    for (int r = 0; r < MATCH_RULES; r++) begin
      hit_pat[r]  = (paddr == trace_pkg::apb_addr_t'(trace_pkg::ADDR_PATTERN_BASE
                             + trace_pkg::RULE_STRIDE * r));
      hit_mask[r] = (paddr == trace_pkg::apb_addr_t'(trace_pkg::ADDR_PATTERN_BASE
                             + trace_pkg::RULE_STRIDE * r + trace_pkg::MASK_OFFSET));
      hit_cnt[r]  = (paddr == trace_pkg::apb_addr_t'(trace_pkg::ADDR_COUNT_BASE
                             + trace_pkg::COUNT_STRIDE * r));
    end
  end

  assign mapped    = hit_ctrl | hit_rule_en | hit_status | hit_arm
                   | (|hit_pat) | (|hit_mask) | (|hit_cnt);
  assign read_only = hit_status | (|hit_cnt);

  // unmapped address, or a write to status / counts
  assign pslverr = access & (~mapped | (pwrite & read_only));

  // read mux, decode is one-hot
  always_comb begin
    prdata = '0;
    if (hit_ctrl) begin
      prdata[0] = trigger_enable;
      prdata[trace_pkg::CTRL_NUM_LSB +: NUM_W] = num_triggers;
    end
    if (hit_rule_en) begin
      prdata[MATCH_RULES-1:0] = pattern_enable;
      prdata[trace_pkg::RULE_EN_TRG_LSB +: MATCH_RULES] = trig_enable;
    end
    if (hit_status) begin
      prdata[NUM_W-1:0] = triggers_generated;
      prdata[trace_pkg::STATUS_ARMED] = armed;
    end
    for (int r = 0; r < MATCH_RULES; r++) begin
      if (hit_pat[r])
        prdata[BUF_W-1:0] = rule_patterns[r*BUF_W +: BUF_W];
      if (hit_mask[r])
        prdata[BUF_W-1:0] = rule_masks[r*BUF_W +: BUF_W];
      if (hit_cnt[r])
        prdata[CNT_W-1:0] = match_counts[r*CNT_W +: CNT_W];
    end
  end

  // writes land at the edge closing the access phase
  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      trigger_enable <= 1'b0;
      num_triggers   <= '0;
      pattern_enable <= '0;
      trig_enable    <= '0;
      rule_patterns  <= '0;
      rule_masks     <= '0;
      arm_pulse      <= 1'b0;
    end else begin
      arm_pulse <= wr_en & hit_arm & pwdata[0];  // single cycle
      if (wr_en & hit_ctrl) begin
        trigger_enable <= pwdata[0];
        num_triggers   <= pwdata[trace_pkg::CTRL_NUM_LSB +: NUM_W];
      end
      if (wr_en & hit_rule_en) begin
        pattern_enable <= pwdata[MATCH_RULES-1:0];
        trig_enable    <= pwdata[trace_pkg::RULE_EN_TRG_LSB +: MATCH_RULES];
      end
      for (int r = 0; r < MATCH_RULES; r++) begin
        if (wr_en & hit_pat[r])
          rule_patterns[r*BUF_W +: BUF_W] <= pwdata[BUF_W-1:0];
        if (wr_en & hit_mask[r])
          rule_masks[r*BUF_W +: BUF_W] <= pwdata[BUF_W-1:0];
      end
    end
  end

  // error response only in an access phase that follows its setup phase
  a_slverr_in_access : assert property (
    @(posedge trigger_clk) disable iff (reset)
    pslverr |-> (psel && penable && $past(psel && !penable))
  );

endmodule

`default_nettype wire

// File: logic/trace_top.sv
// trace pattern trigger top level with APB configuration
`timescale 1ns/1ps
`default_nettype none

module trace_top #(
  parameter int BUFFER_BYTES = 4,   // 1 to 4
  parameter int MATCH_RULES  = 4    // 1 to 6
) (
  input  wire                          trigger_clk,
  input  wire                          reset,
  // APB slave
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire trace_pkg::apb_addr_t    paddr,
  input  wire trace_pkg::apb_data_t    pwdata,
  output trace_pkg::apb_data_t         prdata,
  output logic                         pready,
  output logic                         pslverr,
  // trace stream
  input  wire trace_pkg::trace_byte_t  trace_byte,
  input  wire                          trace_valid,
  output logic                         trig_out
);

  localparam int BUF_W = BUFFER_BYTES * 8;

  logic [MATCH_RULES*BUF_W-1:0] rule_patterns;
  logic [MATCH_RULES*BUF_W-1:0] rule_masks;
  logic [MATCH_RULES-1:0]       pattern_enable;
  logic [MATCH_RULES-1:0]       trig_enable;
  logic                         trigger_enable;
  trace_pkg::trig_num_t         num_triggers;
  logic                         arm_pulse;
  logic [MATCH_RULES*8-1:0]     match_counts;
  logic [MATCH_RULES-1:0]       rule_match;
  logic                         armed;
  trace_pkg::trig_num_t         triggers_generated;

  trace_regs #(
    .BUFFER_BYTES       (BUFFER_BYTES),
    .MATCH_RULES        (MATCH_RULES)
  ) i_trace_regs (
    .trigger_clk        (trigger_clk),
    .reset              (reset),
    .psel               (psel),
    .penable            (penable),
    .pwrite             (pwrite),
    .paddr              (paddr),
    .pwdata             (pwdata),
    .prdata             (prdata),
    .pready             (pready),
    .pslverr            (pslverr),
    .match_counts       (match_counts),
    .armed              (armed),
    .triggers_generated (triggers_generated),
    .rule_patterns      (rule_patterns),
    .rule_masks         (rule_masks),
    .pattern_enable     (pattern_enable),
    .trig_enable        (trig_enable),
    .trigger_enable     (trigger_enable),
    .num_triggers       (num_triggers),
    .arm_pulse          (arm_pulse)
  );

  trace_matcher #(
    .BUFFER_BYTES       (BUFFER_BYTES),
    .MATCH_RULES        (MATCH_RULES)
  ) i_trace_matcher (
    .trigger_clk        (trigger_clk),
    .reset              (reset),
    .trace_byte         (trace_byte),
    .trace_valid        (trace_valid),
    .rule_patterns      (rule_patterns),
    .rule_masks         (rule_masks),
    .pattern_enable     (pattern_enable),
    .rule_match         (rule_match),
    .match_counts       (match_counts)
  );

  trace_trigger #(
    .BUFFER_BYTES       (BUFFER_BYTES),
    .MATCH_RULES        (MATCH_RULES)
  ) i_trace_trigger (
    .trigger_clk        (trigger_clk),
    .reset              (reset),
    .rule_match         (rule_match),
    .trig_enable        (trig_enable),
    .trigger_enable     (trigger_enable),
    .num_triggers       (num_triggers),
    .arm_pulse          (arm_pulse),
    .trig_out           (trig_out),
    .armed              (armed),
    .triggers_generated (triggers_generated)
  );

endmodule

`default_nettype wire

// File: logic/trace_trigger.sv
// arming control and limited one-cycle trigger pulse generation
`timescale 1ns/1ps
`default_nettype none

module trace_trigger #(
  parameter int BUFFER_BYTES = 4,
  parameter int MATCH_RULES  = 4
) (
  input  wire                          trigger_clk,
  input  wire                          reset,
  input  wire [MATCH_RULES-1:0]        rule_match,
  input  wire [MATCH_RULES-1:0]        trig_enable,
  input  wire                          trigger_enable,
  input  wire trace_pkg::trig_num_t    num_triggers,
  input  wire                          arm_pulse,
  output logic                         trig_out,
  output logic                         armed,
  output trace_pkg::trig_num_t         triggers_generated
);

  // window depth is not needed here, checked for sanity only
  localparam int BUF_W = BUFFER_BYTES * 8;

  logic                 under_limit;
  logic                 fire;
  trace_pkg::trig_num_t next_count;

  assign under_limit = (triggers_generated < num_triggers);
  assign fire        = armed & trigger_enable & under_limit
                     & (|(rule_match & trig_enable));
  assign next_count  = triggers_generated + trace_pkg::trig_num_t'(1);

  always_ff @(posedge trigger_clk) begin
    if (reset) begin
      trig_out           <= 1'b0;
      armed              <= 1'b0;
      triggers_generated <= '0;
    end else begin
      trig_out <= fire;  // one cycle per qualifying match
      if (arm_pulse && (num_triggers != '0)) begin
        armed              <= 1'b1;
        triggers_generated <= '0;
      end else if (fire) begin
        triggers_generated <= next_count;
        if (next_count >= num_triggers)
          armed <= 1'b0;   // limit reached
      end else if (armed && !under_limit) begin
        armed <= 1'b0;     // limit lowered while armed
      end
    end
  end

  // pulse needs armed the cycle before
  a_trig_after_armed : assert property (
    @(posedge trigger_clk) disable iff (reset)
    trig_out |-> $past(armed)
  );

  // while armed the count stays below the limit, unless the limit just moved
  a_count_in_limit : assert property (
    @(posedge trigger_clk) disable iff (reset)
    armed |-> ((triggers_generated < num_triggers) || $changed(num_triggers))
  );

  initial begin
    if (BUF_W < 8 || BUF_W > 32 || MATCH_RULES < 1 || MATCH_RULES > 6)
      $error("trace_trigger parameters out of range");
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
logic/trace_pkg.sv
logic/trace_regs.sv
logic/trace_matcher.sv
logic/trace_trigger.sv
logic/trace_top.sv
sim/tb_trace_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_trace_top -o tb_trace_top

status=0
./obj_dir/tb_trace_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation failed, exit status $status"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
echo "simulation passed"

// File: include/tb_checks.svh
// testbench compare tasks and APB master access task
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_data(input string name, input trace_pkg::apb_data_t exp,
                          input trace_pkg::apb_data_t act);
  if (act !== exp) begin
    $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_count(input string name, input trace_pkg::match_count_t exp,
                           input trace_pkg::match_count_t act);
  if (act !== exp) begin
    $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    abort_run();
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("mismatch %s: expected %b, actual %b", name, exp, act);
    abort_run();
  end
endtask

// setup phase, then access phase sampled in the middle of the low clock half
task automatic apb_access(input string name, input logic write,
                          input trace_pkg::apb_addr_t addr, input trace_pkg::apb_data_t wdata,
                          output trace_pkg::apb_data_t rdata, output logic err);
  tick(1'b0, name);
  trace_valid = 1'b0;
  trace_byte  = trace_pkg::trace_byte_t'($urandom);  // idle filler, never sampled
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = write;
  paddr   = addr;
  pwdata  = wdata;
  tick(1'b0, name);
  penable = 1'b1;
  #10;
  check_bit({name, " pready"}, 1'b1, pready);
  rdata = prdata;
  err   = pslverr;
endtask

`endif

// File: sim/tb_trace_top.sv
// testbench for the trace pattern trigger, table driven over APB and the trace stream
`timescale 1ns/1ps
`default_nettype none

module tb_trace_top;

  localparam int K_WRITE  = 0;
  localparam int K_READ   = 1;
  localparam int K_COUNT  = 2;
  localparam int K_BYTE   = 3;
  localparam int MAX_ROWS = 64;

  logic                   trigger_clk;
  logic                   reset;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  trace_pkg::apb_addr_t   paddr;
  trace_pkg::apb_data_t   pwdata;
  trace_pkg::apb_data_t   prdata;
  logic                   pready;
  logic                   pslverr;
  trace_pkg::trace_byte_t trace_byte;
  logic                   trace_valid;
  logic                   trig_out;

  // stimulus table
  string                row_name [MAX_ROWS];
  int                   row_kind [MAX_ROWS];
  trace_pkg::apb_addr_t row_addr [MAX_ROWS];
  trace_pkg::apb_data_t row_data [MAX_ROWS];
  logic                 row_err  [MAX_ROWS];
  logic                 row_trig [MAX_ROWS];
  int                   n_rows;

  // expected trig_out, checked three falling edges after the byte is driven
  logic  trig_exp [3];
  string trig_tag [3];

  int cycle_count = 0;
  int cycle_limit;

  trace_top #(
    .BUFFER_BYTES (4),
    .MATCH_RULES  (4)
  ) i_trace_top (
    .trigger_clk (trigger_clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .trace_byte  (trace_byte),
    .trace_valid (trace_valid),
    .trig_out    (trig_out)
  );

  always #20 trigger_clk = ~trigger_clk;

  `include "tb_checks.svh"

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  // one falling edge, trig_out check and pipeline shift
  task automatic tick(input logic exp_trig, input string tag);
    @(negedge trigger_clk);
    check_bit({trig_tag[2], " trig_out"}, trig_exp[2], trig_out);
    trig_exp[2] = trig_exp[1];
    trig_tag[2] = trig_tag[1];
    trig_exp[1] = trig_exp[0];
    trig_tag[1] = trig_tag[0];
    trig_exp[0] = exp_trig;
    trig_tag[0] = tag;
  endtask

  task automatic send_byte(input string name, input trace_pkg::trace_byte_t b,
                           input logic exp_trig);
    tick(exp_trig, name);
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    trace_valid = 1'b1;
    trace_byte  = b;
  endtask

  task automatic add_row(input string name, input int kind, input trace_pkg::apb_addr_t addr,
                         input trace_pkg::apb_data_t data, input logic err, input logic trig);
    row_name[n_rows] = name;
    row_kind[n_rows] = kind;
    row_addr[n_rows] = addr;
    row_data[n_rows] = data;
    row_err[n_rows]  = err;
    row_trig[n_rows] = trig;
    n_rows++;
  endtask

  task automatic add_byte(input string name, input trace_pkg::trace_byte_t b, input logic trig);
    add_row(name, K_BYTE, 8'h00, {24'h0, b}, 1'b0, trig);
  endtask

  function automatic trace_pkg::apb_addr_t pattern_addr(input int r);
    return trace_pkg::apb_addr_t'(trace_pkg::ADDR_PATTERN_BASE + 8 * r);
  endfunction

  function automatic trace_pkg::apb_addr_t mask_addr(input int r);
    return trace_pkg::apb_addr_t'(trace_pkg::ADDR_PATTERN_BASE + 8 * r + 4);
  endfunction

  function automatic trace_pkg::apb_addr_t count_addr(input int r);
    return trace_pkg::apb_addr_t'(trace_pkg::ADDR_COUNT_BASE + 4 * r);
  endfunction

  // rule0 ab,cd in the two newest bytes (trigger), rule1 mask 0, rule2 newest cd,
  // rule3 left disabled
  task automatic build_table();
    n_rows = 0;
    add_row("reset ctrl", K_READ, trace_pkg::ADDR_CTRL, 32'h0, 1'b0, 1'b0);
    add_row("reset count0", K_COUNT, count_addr(0), 32'h0, 1'b0, 1'b0);
    add_row("reset status", K_READ, trace_pkg::ADDR_STATUS, 32'h0, 1'b0, 1'b0);
    add_row("wr pattern0", K_WRITE, pattern_addr(0), 32'h0000_ABCD, 1'b0, 1'b0);
    add_row("wr mask0", K_WRITE, mask_addr(0), 32'h0000_FFFF, 1'b0, 1'b0);
    add_row("wr pattern1", K_WRITE, pattern_addr(1), 32'h1234_5678, 1'b0, 1'b0);
    add_row("wr pattern2", K_WRITE, pattern_addr(2), 32'h0000_00CD, 1'b0, 1'b0);
    add_row("wr mask2", K_WRITE, mask_addr(2), 32'h0000_00FF, 1'b0, 1'b0);
    add_row("wr ctrl", K_WRITE, trace_pkg::ADDR_CTRL, 32'h21, 1'b0, 1'b0);       // 2 pulses
    add_row("wr rule_en", K_WRITE, trace_pkg::ADDR_RULE_EN, 32'h107, 1'b0, 1'b0);
    add_row("rd pattern0", K_READ, pattern_addr(0), 32'h0000_ABCD, 1'b0, 1'b0);
    add_row("rd pattern1", K_READ, pattern_addr(1), 32'h1234_5678, 1'b0, 1'b0);
    add_row("rd mask0", K_READ, mask_addr(0), 32'h0000_FFFF, 1'b0, 1'b0);
    add_row("rd mask2", K_READ, mask_addr(2), 32'h0000_00FF, 1'b0, 1'b0);
    add_row("rd ctrl", K_READ, trace_pkg::ADDR_CTRL, 32'h21, 1'b0, 1'b0);
    add_row("rd rule_en", K_READ, trace_pkg::ADDR_RULE_EN, 32'h107, 1'b0, 1'b0);
    add_row("rd unmapped", K_READ, 8'hFC, 32'h0, 1'b1, 1'b0);
    add_row("wr status", K_WRITE, trace_pkg::ADDR_STATUS, 32'hFFFF, 1'b1, 1'b0);
    add_row("status kept", K_READ, trace_pkg::ADDR_STATUS, 32'h0, 1'b0, 1'b0);
    add_row("arm", K_WRITE, trace_pkg::ADDR_ARM, 32'h1, 1'b0, 1'b0);
    add_row("status armed", K_READ, trace_pkg::ADDR_STATUS, 32'h100, 1'b0, 1'b0);
    // window low half after each byte in the comment
    add_byte("a1", 8'hAB, 1'b0);  // 00ab
    add_byte("a2", 8'hCD, 1'b1);  // abcd, first pulse
    add_byte("a3", 8'h00, 1'b0);
    add_byte("a4", 8'hAB, 1'b0);
    add_byte("a5", 8'hCD, 1'b1);  // second pulse, disarms
    add_byte("a6", 8'hCD, 1'b0);  // cdcd, rule2 only
    add_byte("a7", 8'hAB, 1'b0);
    add_byte("a8", 8'hCD, 1'b0);  // match past the limit
    add_byte("a9", 8'h11, 1'b0);
    add_row("count0 a", K_COUNT, count_addr(0), 32'd3, 1'b0, 1'b0);
    add_row("count1 a", K_COUNT, count_addr(1), 32'd9, 1'b0, 1'b0);   // every byte
    add_row("count2 a", K_COUNT, count_addr(2), 32'd4, 1'b0, 1'b0);
    add_row("count3 a", K_COUNT, count_addr(3), 32'd0, 1'b0, 1'b0);
    add_row("status done", K_READ, trace_pkg::ADDR_STATUS, 32'h2, 1'b0, 1'b0);
    add_row("rearm", K_WRITE, trace_pkg::ADDR_ARM, 32'h1, 1'b0, 1'b0);
    add_row("status rearmed", K_READ, trace_pkg::ADDR_STATUS, 32'h100, 1'b0, 1'b0);
    add_byte("b1", 8'hCD, 1'b0);  // 11cd
    add_byte("b2", 8'hCD, 1'b0);  // cdcd
    add_row("count2 b", K_COUNT, count_addr(2), 32'd6, 1'b0, 1'b0);
    add_row("count1 b", K_COUNT, count_addr(1), 32'd11, 1'b0, 1'b0);
    add_row("status b", K_READ, trace_pkg::ADDR_STATUS, 32'h100, 1'b0, 1'b0);
  endtask

  always @(posedge trigger_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      abort_run();
    end
  end

  initial begin
    trace_pkg::apb_data_t rdata;
    logic                 err;
    void'($urandom(70));
    trigger_clk = 1'b0;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    trace_byte  = '0;
    trace_valid = 1'b0;
    for (int s = 0; s < 3; s++) begin
      trig_exp[s] = 1'b0;
      trig_tag[s] = "reset";
    end
    build_table();
    cycle_limit = n_rows * 8 + 50;
    repeat (3) tick(1'b0, "reset");
    reset = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      case (row_kind[i])
        K_WRITE: begin
          apb_access(row_name[i], 1'b1, row_addr[i], row_data[i], rdata, err);
          check_bit({row_name[i], " pslverr"}, row_err[i], err);
        end
        K_READ: begin
          apb_access(row_name[i], 1'b0, row_addr[i], '0, rdata, err);
          check_data(row_name[i], row_data[i], rdata);
          check_bit({row_name[i], " pslverr"}, row_err[i], err);
        end
        K_COUNT: begin
          apb_access(row_name[i], 1'b0, row_addr[i], '0, rdata, err);
          check_count(row_name[i], trace_pkg::match_count_t'(row_data[i]),
                      trace_pkg::match_count_t'(rdata));
          check_bit({row_name[i], " pslverr"}, row_err[i], err);
        end
        default: send_byte(row_name[i], trace_pkg::trace_byte_t'(row_data[i]), row_trig[i]);
      endcase
    end
    // flush the trig_out pipeline
    repeat (3) begin
      tick(1'b0, "drain");
      psel        = 1'b0;
      penable     = 1'b0;
      trace_valid = 1'b0;
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
